//--- verilog.f
src/ik_pkg.sv
src/ik_param_regs.sv
src/fk_sequencer.sv
src/loop_counter.sv
src/cordic_sincos.sv
src/dh_link_matrix.sv
src/frame_mac.sv
src/ik_swift_interface.sv
verif/fk_checker.sv
verif/tb_ik_swift.sv

//--- verif/fk_stimulus.txt
# records: test <name> | w <addr> <hex byte> | p <joint> <theta> <d> <a> <alpha> | s (start, wait)
# b <n> (start, n writes and a start while busy) | e <j0> <j1> <row> <col0> <col1> <col2> <col3>
test reset_state
e 0 5 0 0 0 0 0
e 0 5 1 0 0 0 0
e 0 5 2 0 0 0 0
e 0 5 3 0 0 0 1
e 6 7 3 0 0 0 0
test zero_params
s
e 0 5 0 1 0 0 0
e 0 5 1 0 1 0 0
e 0 5 2 0 0 1 0
test single_joint
p 0 1.5707963 0 1.0 0
s
e 0 5 0 0 -1 0 0
e 0 5 1 1 0 0 1
e 0 5 2 0 0 1 0
test arm_chain
p 0 1.5707963 0.5 0 1.5707963
p 1 2.3561945 0 1.0 0
p 2 -1.5707963 0 0.75 -1.5707963
p 3 3.1415927 0.25 0 1.5707963
p 4 -2.0943951 0 0.5 0
p 5 0 0 0.25 -1.5707963
# joint 5 d = 0.125 byte by byte
w 97 00
w 98 00
w 99 80
w 100 00
s
e 0 0 0 0 0 1 0
e 0 0 1 1 0 0 0
e 0 0 2 0 1 0 0.5
e 1 1 0 0 0 1 0
e 1 1 1 -0.7071068 -0.7071068 0 -0.7071068
e 1 1 2 0.7071068 -0.7071068 0 1.2071068
e 2 2 0 0 -1 0 0
e 2 2 1 0.7071068 0 -0.7071068 -0.1767767
e 2 2 2 0.7071068 0 0.7071068 1.7374369
e 3 3 0 0 0 -1 0
e 3 3 1 -0.7071068 -0.7071068 0 -0.3535534
e 3 3 2 -0.7071068 0.7071068 0 1.9142136
e 4 4 0 0 0 -1 0
e 4 4 1 0.9659258 -0.2588190 0 0.1294095
e 4 4 2 -0.2588190 -0.9659258 0 1.7848040
e 5 5 0 0 1 0 -0.125
e 5 5 1 0.9659258 0 -0.2588190 0.3708910
e 5 5 2 -0.2588190 0 -0.9659258 1.7200993
test locked_during_busy
b 12
e 1 1 1 -0.7071068 -0.7071068 0 -0.7071068
e 1 1 2 0.7071068 -0.7071068 0 1.2071068
e 5 5 0 0 1 0 -0.125
e 5 5 1 0.9659258 0 -0.2588190 0.3708910
e 5 5 2 -0.2588190 0 -0.9659258 1.7200993
test readout_latency
e 6 7 0 0 0 0 0
e 6 7 2 0 0 0 0
e 0 5 3 0 0 0 1
e 4 4 1 0.9659258 -0.2588190 0 0.1294095
e 2 2 2 0.7071068 0 0.7071068 1.7374369

//--- verif/tb_ik_swift.sv
// run from the project root, stimulus comes from verif/fk_stimulus.txt; bus writes take one cycle
`timescale 1ns/1ps

module tb_ik_swift;
	import ik_pkg::*;

	localparam STIM_FILE = "verif/fk_stimulus.txt";

	logic clk;
	logic reset;
	logic chipselect;
	logic write;
	logic [6:0] address;
	logic [7:0] writedata;
	mat_sel_t sel;
	fx_t data;
	logic busy;
	logic done;

	logic chk_en;
	fx_t chk_exp;
	mat_sel_t chk_sel;
	logic [8*24-1:0] test_name;
	logic expect_idle;
	int exp_dones;
	int file_errors;
	logic finish_req;
	int errors;
	logic report_done;

	integer seed;
	int limit_cycles = 0;

	ik_swift_interface dut_i (
		.clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
		.address(address), .writedata(writedata), .sel(sel), .data(data),
		.busy(busy), .done(done)
	);

	fk_checker checker_i (
		.clk(clk), .reset(reset), .busy(busy), .done(done), .data(data),
		.chk_en(chk_en), .chk_exp(chk_exp), .chk_sel(chk_sel), .test_name(test_name),
		.expect_idle(expect_idle), .exp_dones(exp_dones), .other_errors(file_errors),
		.finish_req(finish_req), .errors(errors), .report_done(report_done)
	);

	always #5 clk = ~clk;

	function automatic fx_t to_fixed(input real x);
		real scaled;
		integer v;
		scaled = x * (2.0 ** FX_FRAC);
		v = $rtoi(scaled + ((scaled < 0.0) ? -0.5 : 0.5)); // round to nearest
		return v[FX_W-1:0];
	endfunction

	// entered and left on a falling edge
	task automatic bus_write(input logic [6:0] addr, input logic [7:0] val);
		chipselect = 1'b1;
		write = 1'b1;
		address = addr;
		writedata = val;
		@(negedge clk);
		chipselect = 1'b0;
		write = 1'b0;
	endtask

	task automatic write_word(input logic [6:0] base, input fx_t v);
		bus_write(base, {5'd0, v[FX_W-1:24]}); // top 3 bits first
		bus_write(base + 7'd1, v[23:16]);
		bus_write(base + 7'd2, v[15:8]);
		bus_write(base + 7'd3, v[7:0]);
	endtask

	task automatic load_joint(input int j, input real th, input real d, input real a,
			input real al);
		logic [6:0] base;
		base = 7'(PARAM_BASE + j * NUM_PARAMS * 4);
		write_word(base, to_fixed(th));
		write_word(base + 7'd4, to_fixed(d));
		write_word(base + 7'd8, to_fixed(a));
		write_word(base + 7'd12, to_fixed(al));
	endtask

	task automatic wait_done();
		while (!done)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic start_run();
		expect_idle = 1'b0;
		exp_dones = exp_dones + 1;
		bus_write(7'(START_ADDR), 8'h01);
		wait_done();
	endtask

	// garbage writes and a second start, all while busy
	task automatic locked_run(input int n);
		int i;
		int r;
		int span;
		span = NUM_JOINTS * NUM_PARAMS * 4;
		expect_idle = 1'b0;
		exp_dones = exp_dones + 1;
		bus_write(7'(START_ADDR), 8'h01);
		while (!busy)
			@(negedge clk);
		for (i = 0; i < n; i++) begin
			r = $random(seed);
			address = 7'(PARAM_BASE + (r & 32'h7fff_ffff) % span);
			r = $random(seed);
			bus_write(address, r[7:0]);
		end
		bus_write(7'(START_ADDR), 8'h01);
		wait_done();
	endtask

	// new select every cycle, expected value follows one cycle behind
	task automatic check_row(input int j, input int row, input real e0, input real e1,
			input real e2, input real e3);
		fx_t exp_val [4];
		int c;
		exp_val[0] = to_fixed(e0);
		exp_val[1] = to_fixed(e1);
		exp_val[2] = to_fixed(e2);
		exp_val[3] = to_fixed(e3);
		for (c = 0; c < 5; c++) begin
			chk_sel = sel;
			chk_en = (c > 0);
			if (c > 0)
				chk_exp = exp_val[c-1];
			if (c < 4) begin
				sel.joint = 3'(j);
				sel.row = 2'(row);
				sel.col = 2'(c);
			end
			@(negedge clk);
		end
		chk_en = 1'b0;
	endtask

	initial begin
		integer fd;
		integer n;
		int want;
		int num_lines;
		int j;
		int j0;
		int j1;
		int rw;
		int cnt;
		logic [8*8-1:0] kind;
		logic [8*128-1:0] line;
		real r0;
		real r1;
		real r2;
		real r3;
		clk = 1'b0;
		reset = 1'b1;
		chipselect = 1'b0;
		write = 1'b0;
		address = '0;
		writedata = '0;
		sel = '0;
		chk_en = 1'b0;
		chk_exp = '0;
		chk_sel = '0;
		test_name = "none";
		expect_idle = 1'b0;
		exp_dones = 0;
		file_errors = 0;
		finish_req = 1'b0;
		seed = 13;
		num_lines = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %0s.", STIM_FILE);
			$display("Some tests failed");
			$finish;
		end else begin
			while ($fgets(line, fd) > 0)
				num_lines++;
			$fclose(fd);
			limit_cycles = num_lines * 200 + 1000;
			fd = $fopen(STIM_FILE, "r");
			repeat (10) @(negedge clk);
			reset = 1'b0;
			expect_idle = 1'b1;
			while ($fscanf(fd, "%s", kind) == 1) begin
				n = 0;
				want = 0; // fields the record must carry
				if (kind == "#") begin
					n = $fgets(line, fd); // rest of the comment
				end else if (kind == "test") begin
					want = 1;
					n = $fscanf(fd, "%s", test_name);
					$display("running %0s", test_name);
				end else if (kind == "w") begin
					want = 2;
					n = $fscanf(fd, "%d %h", rw, cnt);
					bus_write(7'(rw), 8'(cnt));
				end else if (kind == "p") begin
					want = 5;
					n = $fscanf(fd, "%d %f %f %f %f", j, r0, r1, r2, r3);
					load_joint(j, r0, r1, r2, r3);
				end else if (kind == "s") begin
					start_run();
				end else if (kind == "b") begin
					want = 1;
					n = $fscanf(fd, "%d", cnt);
					locked_run(cnt);
				end else if (kind == "e") begin
					want = 7;
					n = $fscanf(fd, "%d %d %d %f %f %f %f", j0, j1, rw, r0, r1, r2, r3);
					for (j = j0; j <= j1; j++)
						check_row(j, rw, r0, r1, r2, r3);
				end else begin
					file_errors++;
					$display("The stimulus file holds an unknown record kind %0s.", kind);
				end
				if (n < want) begin
					file_errors++;
					$display("A %0s record in the stimulus file has too few fields.", kind);
				end
			end
			$fclose(fd);
			@(negedge clk);
			finish_req = 1'b1;
			while (!report_done)
				@(negedge clk);
			if (errors == 0)
				$display("All tests passed");
			else
				$display("Some tests failed");
			$finish;
		end
	end

	// watchdog, armed once the record count is known
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", limit_cycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- verif/fk_checker.sv
// readout tolerance is 256 LSB per element; done pulses are counted over the whole run
`timescale 1ns/1ps

module fk_checker (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input ik_pkg::fx_t data,
	input logic chk_en,
	input ik_pkg::fx_t chk_exp,
	input ik_pkg::mat_sel_t chk_sel,
	input logic [8*24-1:0] test_name,
	input logic expect_idle,
	input int exp_dones,
	input int other_errors,
	input logic finish_req,
	output int errors,
	output logic report_done
);
	import ik_pkg::*;

	localparam int TOL = 256; // 2^-10 in Q9.18

	int checks = 0;
	int mismatches = 0;
	int protocol_errors = 0;
	int dones = 0;
	logic done_q = 1'b0;
	logic busy_q = 1'b0; // busy one edge back
	logic signed [FX_W:0] diff;

	assign diff = data - chk_exp;
	assign errors = mismatches + protocol_errors + other_errors;

	initial report_done = 1'b0;

	always @(posedge clk) begin
		if (!reset) begin
			// data still holds the element selected two edges back
			if (chk_en) begin
				checks = checks + 1;
				if (diff > TOL || diff < -TOL) begin
					mismatches = mismatches + 1;
					$display("Mismatch in %0s at T%0d[%0d][%0d]: expected %0d (%f), actual %0d (%f)",
						test_name, chk_sel.joint, chk_sel.row, chk_sel.col,
						chk_exp, $itor(chk_exp) / (2.0 ** FX_FRAC),
						data, $itor(data) / (2.0 ** FX_FRAC));
				end
			end
			if (expect_idle && (busy || done)) begin
				protocol_errors = protocol_errors + 1;
				$display("Busy or done went high before any start was written.");
			end
			if (done && busy) begin
				protocol_errors = protocol_errors + 1;
				$display("Busy was still high in the cycle where done pulsed.");
			end
			if (done && !busy_q) begin
				protocol_errors = protocol_errors + 1;
				$display("Busy was not high in the cycle before done pulsed.");
			end
			if (done && done_q) begin
				protocol_errors = protocol_errors + 1;
				$display("Done stayed high for more than one cycle.");
			end
			if (done)
				dones = dones + 1;
			done_q = done;
			busy_q = busy;
		end
		if (finish_req && !report_done) begin
			if (dones != exp_dones) begin
				protocol_errors = protocol_errors + 1;
				$display("The design gave %0d done pulses where %0d starts were accepted.",
					dones, exp_dones);
			end
			$display("checks %0d, mismatches %0d, protocol errors %0d, other errors %0d",
				checks, mismatches, protocol_errors, other_errors);
			report_done = 1'b1;
		end
	end

endmodule

//--- src/ik_swift_interface.sv
// write-only host bus; poll busy or wait for done before reading frames
`timescale 1ns/1ps

module ik_swift_interface (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic write,
	input logic [6:0] address,
	input logic [7:0] writedata,
	input ik_pkg::mat_sel_t sel,
	output ik_pkg::fx_t data,
	output logic busy,
	output logic done
);
	import ik_pkg::*;

	dh_table_t params;
	logic start;
	fx_t angle;
	logic trig_go;
	trig_t trig;
	logic trig_ready;
	logic build;
	fx_t cos_theta;
	fx_t sin_theta;
	fx_t cos_alpha;
	fx_t sin_alpha;
	fx_t link_a;
	fx_t link_d;
	link_mat_t link;
	logic cnt_en;
	mac_op_e mac_op;
	logic [2:0] joint;
	logic [1:0] row;
	logic [1:0] col;
	logic [1:0] k;
	logic entry_end;
	logic last_step;

	ik_param_regs u_param_regs (
		.clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
		.busy(busy), .address(address), .writedata(writedata),
		.params(params), .start(start)
	);

	fk_sequencer u_sequencer (
		.clk(clk), .reset(reset), .start(start), .params(params),
		.trig_ready(trig_ready), .trig(trig), .col(col), .k(k),
		.entry_end(entry_end), .last_step(last_step),
		.angle(angle), .trig_go(trig_go), .build(build),
		.cos_theta(cos_theta), .sin_theta(sin_theta),
		.cos_alpha(cos_alpha), .sin_alpha(sin_alpha),
		.link_a(link_a), .link_d(link_d), .cnt_en(cnt_en), .mac_op(mac_op),
		.joint(joint), .busy(busy), .done(done)
	);

	// counter restarts with each accepted start
	loop_counter u_counter (
		.clk(clk), .reset(reset), .en(cnt_en), .clear(start),
		.row(row), .col(col), .k(k), .entry_end(entry_end), .last_step(last_step)
	);

	cordic_sincos u_cordic (
		.clk(clk), .reset(reset), .go(trig_go), .angle(angle),
		.result(trig), .ready(trig_ready)
	);

	dh_link_matrix u_link (
		.clk(clk), .reset(reset), .build(build),
		.cos_theta(cos_theta), .sin_theta(sin_theta),
		.cos_alpha(cos_alpha), .sin_alpha(sin_alpha),
		.link_a(link_a), .link_d(link_d), .link(link)
	);

	frame_mac u_mac (
		.clk(clk), .reset(reset), .mac_op(mac_op), .joint(joint),
		.row(row), .col(col), .k(k), .link(link), .sel(sel), .data(data)
	);

endmodule

//--- src/frame_mac.sv
// frame T[joint] = T[joint-1] * link, identity before joint 0; readout is one cycle late
`timescale 1ns/1ps

module frame_mac (
	input logic clk,
	input logic reset,
	input ik_pkg::mac_op_e mac_op,
	input logic [2:0] joint,
	input logic [1:0] row,
	input logic [1:0] col,
	input logic [1:0] k,
	input ik_pkg::link_mat_t link,
	input ik_pkg::mat_sel_t sel,
	output ik_pkg::fx_t data
);
	import ik_pkg::*;

	link_mat_t frames [NUM_JOINTS];
	fx_t acc;
	logic [1:0] acc_row; // entry being summed, counter moves on before the write
	logic [1:0] acc_col;
	fx_t prev_rk;
	fx_t prev_t;
	fx_t prod;

	always_comb begin
		if (joint == 3'd0) begin
			prev_rk = (row == k) ? FX_ONE : '0;
			prev_t = '0;
		end else begin
			prev_rk = frames[joint - 3'd1][row][k];
			prev_t = frames[joint - 3'd1][row][3];
		end
		prod = fx_mul(prev_rk, link[k][col]);
	end

	always_ff @(posedge clk) begin
		case (mac_op)
			MAC_CLEAR: acc <= prod;
			MAC_ACC: acc <= acc + prod;
			MAC_TRANS: acc <= acc + prod + prev_t;
			default: acc <= acc;
		endcase
		if (mac_op inside {MAC_CLEAR, MAC_ACC, MAC_TRANS}) begin
			acc_row <= row;
			acc_col <= col;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			frames <= '{default: '0};
		else if (mac_op == MAC_WRITE)
			frames[joint][acc_row][acc_col] <= acc;
	end

	// registered readout
	always_ff @(posedge clk) begin
		if (sel.joint >= 3'(NUM_JOINTS))
			data <= '0;
		else if (sel.row == 2'd3)
			data <= (sel.col == 2'd3) ? FX_ONE : '0; // implied bottom row
		else
			data <= frames[sel.joint][sel.row][sel.col];
	end

endmodule

//--- src/dh_link_matrix.sv
// inputs must hold steady while build is high; bottom row 0 0 0 1 is not stored
`timescale 1ns/1ps

module dh_link_matrix (
	input logic clk,
	input logic reset,
	input logic build,
	input ik_pkg::fx_t cos_theta,
	input ik_pkg::fx_t sin_theta,
	input ik_pkg::fx_t cos_alpha,
	input ik_pkg::fx_t sin_alpha,
	input ik_pkg::fx_t link_a,
	input ik_pkg::fx_t link_d,
	output ik_pkg::link_mat_t link
);
	import ik_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			link <= '0;
		end else if (build) begin
			link[0][0] <= cos_theta;
			link[0][1] <= -fx_mul(sin_theta, cos_alpha);
			link[0][2] <= fx_mul(sin_theta, sin_alpha);
			link[0][3] <= fx_mul(link_a, cos_theta); // x offset
			link[1][0] <= sin_theta;
			link[1][1] <= fx_mul(cos_theta, cos_alpha);
			link[1][2] <= -fx_mul(cos_theta, sin_alpha);
			link[1][3] <= fx_mul(link_a, sin_theta);
			link[2][0] <= '0;
			link[2][1] <= sin_alpha;
			link[2][2] <= cos_alpha;
			link[2][3] <= link_d;
		end
	end

endmodule

//--- src/cordic_sincos.sv
// angle must be within -pi..pi; a go while running restarts the rotation
`timescale 1ns/1ps

module cordic_sincos (
	input logic clk,
	input logic reset,
	input logic go,
	input ik_pkg::fx_t angle,
	output ik_pkg::trig_t result,
	output logic ready
);
	import ik_pkg::*;

	fx_t x;
	fx_t y;
	fx_t z; // residual angle
	logic flip; // angle was folded by pi
	logic run;
	logic fin;
	logic [ITER_W-1:0] iter;
	logic last_iter;

	assign last_iter = (iter == ITER_W'(CORDIC_ITERS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			fin <= 1'b0;
			ready <= 1'b0;
		end else begin
			ready <= fin;
			fin <= run && last_iter && !go;
			if (go)
				run <= 1'b1;
			else if (run && last_iter)
				run <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			iter <= '0;
			x <= CORDIC_GAIN_INV;
			y <= '0;
			// fold into +-pi/2, both outputs negate
			if (angle > HALF_PI) begin
				z <= angle - PI;
				flip <= 1'b1;
			end else if (angle < -HALF_PI) begin
				z <= angle + PI;
				flip <= 1'b1;
			end else begin
				z <= angle;
				flip <= 1'b0;
			end
		end else if (run) begin
			iter <= iter + 1'b1;
			if (z[FX_W-1]) begin
				x <= x + (y >>> iter);
				y <= y - (x >>> iter);
				z <= z + ATAN_TAB[iter];
			end else begin
				x <= x - (y >>> iter);
				y <= y + (x >>> iter);
				z <= z - ATAN_TAB[iter];
			end
		end
		if (fin) begin
			result.cos <= flip ? -x : x;
			result.sin <= flip ? -y : y;
		end
	end

endmodule

//--- src/loop_counter.sv
// k fastest, then col, then row; wraps to zero after the last step of a matrix
`timescale 1ns/1ps

module loop_counter (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	output logic [1:0] row,
	output logic [1:0] col,
	output logic [1:0] k,
	output logic entry_end,
	output logic last_step
);

	assign entry_end = (k == 2'd2);
	assign last_step = entry_end && (col == 2'd3) && (row == 2'd2);

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			row <= '0;
			col <= '0;
			k <= '0;
		end else if (en) begin
			if (k == 2'd2) begin
				k <= '0;
				if (col == 2'd3) begin
					col <= '0;
					row <= (row == 2'd2) ? 2'd0 : row + 2'd1;
				end else begin
					col <= col + 2'd1;
				end
			end else begin
				k <= k + 2'd1;
			end
		end
	end

endmodule

//--- src/fk_sequencer.sv
// steps joints 0..5 once per start; expects params to stay put until done
`timescale 1ns/1ps

module fk_sequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input ik_pkg::dh_table_t params,
	input logic trig_ready,
	input ik_pkg::trig_t trig,
	input logic [1:0] col,
	input logic [1:0] k,
	input logic entry_end,
	input logic last_step,
	output ik_pkg::fx_t angle,
	output logic trig_go,
	output logic build,
	output ik_pkg::fx_t cos_theta,
	output ik_pkg::fx_t sin_theta,
	output ik_pkg::fx_t cos_alpha,
	output ik_pkg::fx_t sin_alpha,
	output ik_pkg::fx_t link_a,
	output ik_pkg::fx_t link_d,
	output logic cnt_en,
	output ik_pkg::mac_op_e mac_op,
	output logic [2:0] joint,
	output logic busy,
	output logic done
);
	import ik_pkg::*;

	fk_state_e state;
	logic wr_pend; // write cycle owed for the entry just summed
	logic last_pend;

	assign angle = (state == TRIG_ALPHA) ? params[joint].alpha : params[joint].theta;
	assign link_a = params[joint].a;
	assign link_d = params[joint].d;
	assign build = (state == BUILD); // link valid on the cycle after
	assign busy = (state != IDLE) && (state != FINISH);
	assign done = (state == FINISH);

	// opcode from counter position
	always_comb begin
		cnt_en = 1'b0;
		mac_op = MAC_IDLE;
		if (state == ACCUM) begin
			if (wr_pend) begin
				mac_op = MAC_WRITE;
			end else begin
				cnt_en = 1'b1;
				if (k == 2'd0)
					mac_op = MAC_CLEAR;
				else if (k == 2'd2 && col == 2'd3)
					mac_op = MAC_TRANS;
				else
					mac_op = MAC_ACC;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			joint <= '0;
			trig_go <= 1'b0;
			wr_pend <= 1'b0;
			last_pend <= 1'b0;
		end else begin
			trig_go <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						joint <= '0;
						trig_go <= 1'b1;
						state <= TRIG_THETA;
					end
				end
				TRIG_THETA: begin
					if (trig_ready) begin
						trig_go <= 1'b1; // alpha next
						state <= TRIG_ALPHA;
					end
				end
				TRIG_ALPHA: if (trig_ready) state <= BUILD;
				BUILD: state <= ACCUM;
				ACCUM: begin
					if (wr_pend) begin
						wr_pend <= 1'b0;
						if (last_pend) begin
							last_pend <= 1'b0;
							state <= NEXT_JOINT;
						end
					end else begin
						wr_pend <= entry_end;
						last_pend <= last_step;
					end
				end
				NEXT_JOINT: begin
					if (joint == 3'(NUM_JOINTS - 1)) begin
						state <= FINISH;
					end else begin
						joint <= joint + 3'd1;
						trig_go <= 1'b1;
						state <= TRIG_THETA;
					end
				end
				default: state <= IDLE; // FINISH lasts one cycle
			endcase
		end
	end

	// trig results, held through build
	always_ff @(posedge clk) begin
		if (trig_ready && state == TRIG_THETA) begin
			cos_theta <= trig.cos;
			sin_theta <= trig.sin;
		end
		if (trig_ready && state == TRIG_ALPHA) begin
			cos_alpha <= trig.cos;
			sin_alpha <= trig.sin;
		end
	end

endmodule

//--- src/ik_param_regs.sv
// parameter writes and start are ignored while busy; bytes go top 3 bits first, then big-endian
`timescale 1ns/1ps

module ik_param_regs (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic write,
	input logic busy,
	input logic [6:0] address,
	input logic [7:0] writedata,
	output ik_pkg::dh_table_t params,
	output logic start
);
	import ik_pkg::*;

	logic [6:0] off;
	logic [2:0] jn;
	logic [1:0] pn;
	logic [1:0] ln;
	logic in_range;
	logic wr_en;
	fx_t cur;
	fx_t nxt;

	// joint, parameter and byte lane straight from the offset
	assign off = address - 7'(PARAM_BASE);
	assign jn = 3'(off / (NUM_PARAMS * 4));
	assign pn = off[3:2];
	assign ln = off[1:0];
	assign in_range = (address >= 7'(PARAM_BASE)) && (address < 7'(START_ADDR));
	assign wr_en = chipselect && write && !busy;

	// merge the incoming byte into the addressed word
	always_comb begin
		case (pn)
			2'd0: cur = params[jn].theta;
			2'd1: cur = params[jn].d;
			2'd2: cur = params[jn].a;
			default: cur = params[jn].alpha;
		endcase
		nxt = cur;
		if (ln == 2'd0)
			nxt[FX_W-1:24] = writedata[2:0]; // sign and integer bits
		else
			nxt[(3 - ln) * 8 +: 8] = writedata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			params <= '0;
			start <= 1'b0;
		end else begin
			start <= wr_en && (address == 7'(START_ADDR)); // one-cycle pulse
			if (wr_en && in_range) begin
				case (pn)
					2'd0: params[jn].theta <= nxt;
					2'd1: params[jn].d <= nxt;
					2'd2: params[jn].a <= nxt;
					default: params[jn].alpha <= nxt;
				endcase
			end
		end
	end

endmodule

//--- src/ik_pkg.sv
// Q9.18 fixed point throughout; angles must lie in -pi..pi, host addresses 0-12 hold no state
package ik_pkg;

	localparam int FX_W = 27;
	localparam int FX_FRAC = 18;
	localparam int NUM_JOINTS = 6;
	localparam int NUM_PARAMS = 4;
	localparam int PARAM_BASE = 13; // joint 0 theta, top 3 bits
	localparam int START_ADDR = 109;
	localparam int CORDIC_ITERS = 16;
	localparam int ITER_W = $clog2(CORDIC_ITERS);

	typedef logic signed [FX_W-1:0] fx_t;

	localparam fx_t FX_ONE = fx_t'(1 << FX_FRAC);
	localparam fx_t CORDIC_GAIN_INV = fx_t'(159188); // 1/K, about 0.607253
	localparam fx_t HALF_PI = fx_t'(411775);
	localparam fx_t PI = fx_t'(823550);

	// atan(2^-i) in fixed point
	localparam fx_t ATAN_TAB [0:CORDIC_ITERS-1] = '{
		fx_t'(205887), fx_t'(121542), fx_t'(64220), fx_t'(32599),
		fx_t'(16363), fx_t'(8189), fx_t'(4096), fx_t'(2048),
		fx_t'(1024), fx_t'(512), fx_t'(256), fx_t'(128),
		fx_t'(64), fx_t'(32), fx_t'(16), fx_t'(8)
	};

	typedef struct packed {
		fx_t theta;
		fx_t d; // link offset
		fx_t a; // link distance
		fx_t alpha;
	} dh_param_t;

	typedef dh_param_t [NUM_JOINTS-1:0] dh_table_t;

	typedef struct packed {
		fx_t cos;
		fx_t sin;
	} trig_t;

	typedef fx_t [2:0][3:0] link_mat_t; // [row][col], row 3 implied

	typedef struct packed {
		logic [2:0] joint;
		logic [1:0] row;
		logic [1:0] col;
	} mat_sel_t;

	typedef enum logic [2:0] {
		IDLE,
		TRIG_THETA,
		TRIG_ALPHA,
		BUILD,
		ACCUM,
		NEXT_JOINT,
		FINISH
	} fk_state_e;

	typedef enum logic [2:0] {
		MAC_IDLE,
		MAC_CLEAR, // load first product
		MAC_ACC,
		MAC_TRANS, // product plus previous translation
		MAC_WRITE
	} mac_op_e;

	// rounded fixed-point product, wraps on overflow
	function automatic fx_t fx_mul(fx_t x, fx_t y);
		logic signed [2*FX_W-1:0] p;
		p = x * y;
		return fx_t'((p + (1 << (FX_FRAC - 1))) >>> FX_FRAC);
	endfunction

endpackage
